/* src.f */
+incdir+verilog
verilog/rv_decode_pkg.sv
verilog/base_int_decoder.sv
verilog/muldiv_decoder.sv
verilog/system_decoder.sv
verilog/decode_output_reg.sv
verilog/rv_decode_stage.sv
tb/tb_clock_gen.sv
tb/rv_decode_properties.sv
tb/tb_rv_decode_stage.sv

/* tb/tb_rv_decode_stage.sv */
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module tb_rv_decode_stage;

   localparam int NUM_WORDS   = 420;
   localparam int CATEGORIES  = 12;
   localparam int STIM_CYCLES = 2 + 2 * NUM_WORDS + 4;

   logic                 clk;
   logic                 rst_n;
   logic                 instr_valid;
   logic [`INSTR_W-1:0]  instr;
   logic                 m_sup;
   logic                 valid;
   logic [`EXC_W-1:0]    exception;
   logic                 is_mret;
   logic                 csr_en;
   logic [`CSR_OP_W-1:0] csr_op;
   logic                 csr_src;
   logic [`ALU_OP_W-1:0] alu_op;
   logic                 mdu_en;
   logic [`MDU_OP_W-1:0] mdu_op;
   logic [`CS_W-1:0]     chip_select;
   logic                 rs2_negate;
   logic                 reg_wr_en;
   logic [`WB_W-1:0]     wb_sel;
   logic                 op1_sel;
   logic                 op2_sel;
   logic                 is_load;
   logic                 is_store;
   logic [31:0]          rng;

   tb_clock_gen u_clock_gen (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   rv_decode_stage dut (
      .clk_i            (clk),
      .rst_n_i          (rst_n),
      .instr_valid_i    (instr_valid),
      .instr_i          (instr),
      .is_m_supported_i (m_sup),
      .valid_o          (valid),
      .exception_o      (exception),
      .is_mret_o        (is_mret),
      .csr_en_o         (csr_en),
      .csr_op_o         (csr_op),
      .csr_source_sel_o (csr_src),
      .alu_op_o         (alu_op),
      .mdu_en_o         (mdu_en),
      .mdu_op_o         (mdu_op),
      .chip_select_o    (chip_select),
      .rs2_negate_sel_o (rs2_negate),
      .reg_wr_en_o      (reg_wr_en),
      .wb_sel_o         (wb_sel),
      .op1_sel_o        (op1_sel),
      .op2_sel_o        (op2_sel),
      .is_load_o        (is_load),
      .is_store_o       (is_store)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic next_rand(output logic [31:0] r);
      rng = xorshift32(rng);
      r   = rng;
   endtask

   // Random fields, then the opcode and selector bits of one instruction group
   function automatic logic [`INSTR_W-1:0] build_word(input int cat, input logic [31:0] r);
      logic [`INSTR_W-1:0] w;
      w = r[29:0];
      case (cat)
         0: begin
            w[4:0]   = `OPC_OP;
            w[29:23] = r[31] ? `F7_ALT : `F7_BASE;
         end
         1: begin
            w[4:0] = `OPC_OP_IMM;
            // Shifts need a funct7 of BASE or ALT
            if (w[11:10] == 2'b01)
               w[29:23] = r[31] ? `F7_ALT : `F7_BASE;
         end
         2: w[4:0] = `OPC_LOAD;
         3: w[4:0] = `OPC_STORE;
         4: w[4:0] = `OPC_BRANCH;
         5: begin
            w[4:0] = r[31] ? `OPC_JAL : `OPC_JALR;
            if (r[30])
               w[12:10] = 3'b000;
         end
         6: w[4:0] = r[31] ? `OPC_LUI : `OPC_AUIPC;
         7: begin
            w[4:0]   = `OPC_OP;
            w[29:23] = `F7_MULDIV;
         end
         8: begin
            w[4:0] = `OPC_SYSTEM;
            if (w[12:10] == 3'b000)
               w[12:10] = 3'b011;
         end
         9: begin
            w[4:0]   = `OPC_SYSTEM;
            w[12:10] = 3'b000;
            w[17:13] = 5'd0;
            // Now and then a non-zero rd
            if (r[31:30] != 2'b11)
               w[9:5] = 5'd0;
            case (r[1:0])
               2'd0:    w[29:18] = `F12_ECALL;
               2'd1:    w[29:18] = `F12_EBREAK;
               2'd2:    w[29:18] = `F12_MRET;
               default: w[29:18] = `F12_WFI;
            endcase
         end
         10: begin
            w[4:0]   = `OPC_OP;
            w[29:23] = r[31] ? 7'b0110000 : 7'b0100100;
         end
         // No major opcode here has bits 3..2 equal to 10
         default: w[1:0] = 2'b10;
      endcase
      return w;
   endfunction

   initial begin
      logic [31:0] r;
      int          errors;
      // A valid word held through reset must not get through
      instr_valid = 1'b1;
      instr       = {25'd0, `OPC_LUI};
      m_sup       = 1'b0;
      rng         = 32'd11246;
      wait (rst_n === 1'b1);
      for (int i = 0; i < NUM_WORDS; i++) begin
         next_rand(r);
         @(posedge clk);
         instr_valid <= 1'b1;
         instr       <= build_word(i % CATEGORIES, r);
         m_sup       <= r[30];
         if (r[15:14] == 2'b00) begin
            @(posedge clk);
            instr_valid <= 1'b0;
            instr       <= ~r[29:0];
         end
      end
      @(posedge clk);
      instr_valid <= 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      errors = dut.u_props.fail_count;
      $display("Words sent: %0d, assertion failures: %0d", NUM_WORDS, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      #(2 * STIM_CYCLES * 20);
      $display("Timeout: stimulus did not complete within %0d cycles", 2 * STIM_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

endmodule

/* tb/rv_decode_properties.sv */
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module rv_decode_properties (
   input logic                 clk_i,
   input logic                 rst_n_i,
   input logic                 instr_valid_i,
   input logic [`INSTR_W-1:0]  instr_i,
   input logic                 is_m_supported_i,
   input logic                 valid_o,
   input logic [`EXC_W-1:0]    exception_o,
   input logic                 is_mret_o,
   input logic                 csr_en_o,
   input logic [`CSR_OP_W-1:0] csr_op_o,
   input logic                 csr_source_sel_o,
   input logic [`ALU_OP_W-1:0] alu_op_o,
   input logic                 mdu_en_o,
   input logic [`MDU_OP_W-1:0] mdu_op_o,
   input logic [`CS_W-1:0]     chip_select_o,
   input logic                 rs2_negate_sel_o,
   input logic                 reg_wr_en_o,
   input logic [`WB_W-1:0]     wb_sel_o,
   input logic                 op1_sel_o,
   input logic                 op2_sel_o,
   input logic                 is_load_o,
   input logic                 is_store_o
);

   int          fail_count = 0;
   logic        armed;
   logic        exp_valid;
   logic [24:0] exp_word;
   logic [24:0] act_word;
   logic [7:0]  quiet;

   // Expected control word for one instruction, field order as act_word
   function automatic logic [24:0] model(input logic [`INSTR_W-1:0] w, input logic m_on);
      logic [6:0] f7;
      logic [2:0] f3;
      logic [4:0] opc;
      logic [1:0] exc;
      logic [1:0] csr_op;
      logic [1:0] cs;
      logic [1:0] wb;
      logic [3:0] alu;
      logic [3:0] tbl;
      logic [2:0] mdu_op;
      logic       legal, alt, mret, csr_en, csr_src, mdu_en, neg, wr, op1, op2, ld, st;
      f7  = w[29:23];
      f3  = w[12:10];
      opc = w[4:0];
      alt = (f7 == `F7_ALT);
      {exc, csr_op, cs, wb, alu, mdu_op} = '0;
      {legal, mret, csr_en, csr_src, mdu_en, neg, wr, op1, op2, ld, st} = '0;
      case (f3)
         3'b000:  tbl = (alt && opc == `OPC_OP) ? `ALU_SUB : `ALU_ADD;
         3'b001:  tbl = `ALU_SLL;
         3'b010:  tbl = `ALU_SLT;
         3'b011:  tbl = `ALU_SLTU;
         3'b100:  tbl = `ALU_XOR;
         3'b101:  tbl = alt ? `ALU_SRA : `ALU_SRL;
         3'b110:  tbl = `ALU_OR;
         default: tbl = `ALU_AND;
      endcase
      case (opc)
         `OPC_LOAD: begin
            legal       = f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
            {wr, ld, op2} = 3'b111;
            wb          = `WB_MEM;
         end
         `OPC_STORE: begin
            legal     = f3 inside {3'b000, 3'b001, 3'b010};
            {st, op2} = 2'b11;
         end
         `OPC_BRANCH: begin
            legal      = !(f3 inside {3'b010, 3'b011});
            {op1, op2} = 2'b11;
         end
         `OPC_JALR: begin
            legal     = (f3 == 3'b000);
            {wr, op2} = 2'b11;
            wb        = `WB_LINK;
         end
         `OPC_JAL: begin
            legal          = 1'b1;
            {wr, op1, op2} = 3'b111;
            wb             = `WB_LINK;
         end
         `OPC_AUIPC: begin
            legal          = 1'b1;
            {wr, op1, op2} = 3'b111;
         end
         `OPC_LUI: begin
            legal     = 1'b1;
            {wr, op2} = 2'b11;
            alu       = `ALU_PASS_B;
         end
         `OPC_OP_IMM: begin
            if (f3 == 3'b001)
               legal = (f7 == `F7_BASE);
            else if (f3 == 3'b101)
               legal = (f7 == `F7_BASE) || alt;
            else
               legal = 1'b1;
            {wr, op2} = 2'b11;
            alu       = tbl;
         end
         `OPC_OP: begin
            if (f7 == `F7_MULDIV) begin
               legal        = m_on;
               {mdu_en, wr} = 2'b11;
               mdu_op       = f3;
               cs           = `CS_MDU;
            end else begin
               legal = (f7 == `F7_BASE) || (alt && f3 inside {3'b000, 3'b101});
               wr    = 1'b1;
               alu   = tbl;
               neg   = alt && (f3 == 3'b000);
            end
         end
         `OPC_SYSTEM: begin
            if (f3 != 3'b000) begin
               legal        = (f3 != 3'b100);
               {csr_en, wr} = 2'b11;
               csr_op       = f3[1:0];
               csr_src      = f3[2];
               cs           = `CS_CSR;
            end else if (w[17:13] == 5'd0 && w[9:5] == 5'd0) begin
               case (w[29:18])
                  `F12_ECALL:  {legal, exc} = {1'b1, `EXC_ECALL};
                  `F12_EBREAK: {legal, exc} = {1'b1, `EXC_EBREAK};
                  `F12_MRET:   {legal, mret} = 2'b11;
                  `F12_WFI:    legal = 1'b1;
                  default:     legal = 1'b0;
               endcase
            end
         end
         default: legal = 1'b0;
      endcase
      if (!legal)
         return {`EXC_ILLEGAL, 23'd0};
      return {exc, mret, csr_en, csr_op, csr_src, alu, mdu_en, mdu_op, cs, neg, wr, wb,
              op1, op2, ld, st};
   endfunction

   assign act_word = {exception_o, is_mret_o, csr_en_o, csr_op_o, csr_source_sel_o, alu_op_o,
                      mdu_en_o, mdu_op_o, chip_select_o, rs2_negate_sel_o, reg_wr_en_o,
                      wb_sel_o, op1_sel_o, op2_sel_o, is_load_o, is_store_o};
   assign quiet    = {valid_o, reg_wr_en_o, is_load_o, is_store_o, csr_en_o, mdu_en_o,
                      is_mret_o, exception_o == `EXC_NONE ? 1'b0 : 1'b1};

   initial armed = 1'b0;

   // Expected values one cycle behind the inputs
   always @(posedge clk_i) begin
      armed     <= 1'b1;
      exp_valid <= rst_n_i && instr_valid_i;
      exp_word  <= model(instr_i, is_m_supported_i);
   end

   a_valid_follows: assert property (@(posedge clk_i)
      armed |-> valid_o == $past(rst_n_i && instr_valid_i))
      else begin
         fail_count++;
         $error("Error valid_follows expected %0b actual %0b", $sampled(exp_valid),
                $sampled(valid_o));
      end

   a_idle_quiet: assert property (@(posedge clk_i)
      armed && !$past(rst_n_i && instr_valid_i) |-> quiet == 8'd0)
      else begin
         fail_count++;
         $error("Error idle_quiet expected %b actual %b", 8'd0, $sampled(quiet));
      end

   a_ctrl_word: assert property (@(posedge clk_i)
      armed && $past(rst_n_i && instr_valid_i) |-> act_word == exp_word)
      else begin
         fail_count++;
         $error("Error ctrl_word expected %h actual %h", $sampled(exp_word),
                $sampled(act_word));
      end

   a_illegal_no_effect: assert property (@(posedge clk_i)
      armed && valid_o && exception_o == `EXC_ILLEGAL |->
         {reg_wr_en_o, is_load_o, is_store_o} == 3'b000)
      else begin
         fail_count++;
         $error("Error illegal_no_effect expected %b actual %b", 3'b000,
                $sampled({reg_wr_en_o, is_load_o, is_store_o}));
      end

endmodule

bind rv_decode_stage rv_decode_properties u_props (.*);

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk_o,
   output logic rst_n_o
);

   // 20 ns period
   initial begin
      clk_o = 1'b0;
      forever #10 clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (2) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

/* verilog/rv_decode_stage.sv */
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module rv_decode_stage (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 instr_valid_i,
   input  logic [`INSTR_W-1:0]  instr_i,
   input  logic                 is_m_supported_i,
   output logic                 valid_o,
   output logic [`EXC_W-1:0]    exception_o,
   output logic                 is_mret_o,
   output logic                 csr_en_o,
   output logic [`CSR_OP_W-1:0] csr_op_o,
   output logic                 csr_source_sel_o,
   output logic [`ALU_OP_W-1:0] alu_op_o,
   output logic                 mdu_en_o,
   output logic [`MDU_OP_W-1:0] mdu_op_o,
   output logic [`CS_W-1:0]     chip_select_o,
   output logic                 rs2_negate_sel_o,
   output logic                 reg_wr_en_o,
   output logic [`WB_W-1:0]     wb_sel_o,
   output logic                 op1_sel_o,
   output logic                 op2_sel_o,
   output logic                 is_load_o,
   output logic                 is_store_o
);

   import rv_decode_pkg::*;

   rv_instr_u              instr;
   logic                   int_legal;
   logic [`ALU_OP_W-1:0]   int_alu_op;
   logic                   int_negate;
   logic                   int_wr_en;
   logic [`WB_W-1:0]       int_wb_sel;
   logic                   int_op1_sel;
   logic                   int_op2_sel;
   logic                   int_load;
   logic                   int_store;
   logic                   md_legal;
   logic                   md_en;
   logic [`MDU_OP_W-1:0]   md_op;
   logic                   md_wr_en;
   logic                   sys_legal;
   logic                   sys_csr_en;
   logic [`CSR_OP_W-1:0]   sys_csr_op;
   logic                   sys_csr_src;
   logic                   sys_wr_en;
   logic [`EXC_W-1:0]      sys_exc;
   logic                   sys_mret;

   assign instr = rv_instr_u'(instr_i);

   base_int_decoder u_base_int_decoder (
      .instr_i          (instr),
      .int_legal_o      (int_legal),
      .alu_op_o         (int_alu_op),
      .rs2_negate_sel_o (int_negate),
      .reg_wr_en_o      (int_wr_en),
      .wb_sel_o         (int_wb_sel),
      .op1_sel_o        (int_op1_sel),
      .op2_sel_o        (int_op2_sel),
      .is_load_o        (int_load),
      .is_store_o       (int_store)
   );

   muldiv_decoder u_muldiv_decoder (
      .instr_i          (instr),
      .is_m_supported_i (is_m_supported_i),
      .md_legal_o       (md_legal),
      .mdu_en_o         (md_en),
      .mdu_op_o         (md_op),
      .md_reg_wr_en_o   (md_wr_en)
   );

   system_decoder u_system_decoder (
      .instr_i          (instr),
      .sys_legal_o      (sys_legal),
      .csr_en_o         (sys_csr_en),
      .csr_op_o         (sys_csr_op),
      .csr_source_sel_o (sys_csr_src),
      .sys_reg_wr_en_o  (sys_wr_en),
      .sys_exception_o  (sys_exc),
      .is_mret_o        (sys_mret)
   );

   decode_output_reg u_decode_output_reg (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .instr_valid_i    (instr_valid_i),
      .int_legal_i      (int_legal),
      .alu_op_i         (int_alu_op),
      .rs2_negate_sel_i (int_negate),
      .int_reg_wr_en_i  (int_wr_en),
      .wb_sel_i         (int_wb_sel),
      .op1_sel_i        (int_op1_sel),
      .op2_sel_i        (int_op2_sel),
      .is_load_i        (int_load),
      .is_store_i       (int_store),
      .md_legal_i       (md_legal),
      .mdu_en_i         (md_en),
      .mdu_op_i         (md_op),
      .md_reg_wr_en_i   (md_wr_en),
      .sys_legal_i      (sys_legal),
      .csr_en_i         (sys_csr_en),
      .csr_op_i         (sys_csr_op),
      .csr_source_sel_i (sys_csr_src),
      .sys_reg_wr_en_i  (sys_wr_en),
      .sys_exception_i  (sys_exc),
      .is_mret_i        (sys_mret),
      .valid_o          (valid_o),
      .exception_o      (exception_o),
      .is_mret_o        (is_mret_o),
      .csr_en_o         (csr_en_o),
      .csr_op_o         (csr_op_o),
      .csr_source_sel_o (csr_source_sel_o),
      .alu_op_o         (alu_op_o),
      .mdu_en_o         (mdu_en_o),
      .mdu_op_o         (mdu_op_o),
      .chip_select_o    (chip_select_o),
      .rs2_negate_sel_o (rs2_negate_sel_o),
      .reg_wr_en_o      (reg_wr_en_o),
      .wb_sel_o         (wb_sel_o),
      .op1_sel_o        (op1_sel_o),
      .op2_sel_o        (op2_sel_o),
      .is_load_o        (is_load_o),
      .is_store_o       (is_store_o)
   );

endmodule

/* verilog/decode_output_reg.sv */
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module decode_output_reg (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 instr_valid_i,
   input  logic                 int_legal_i,
   input  logic [`ALU_OP_W-1:0] alu_op_i,
   input  logic                 rs2_negate_sel_i,
   input  logic                 int_reg_wr_en_i,
   input  logic [`WB_W-1:0]     wb_sel_i,
   input  logic                 op1_sel_i,
   input  logic                 op2_sel_i,
   input  logic                 is_load_i,
   input  logic                 is_store_i,
   input  logic                 md_legal_i,
   input  logic                 mdu_en_i,
   input  logic [`MDU_OP_W-1:0] mdu_op_i,
   input  logic                 md_reg_wr_en_i,
   input  logic                 sys_legal_i,
   input  logic                 csr_en_i,
   input  logic [`CSR_OP_W-1:0] csr_op_i,
   input  logic                 csr_source_sel_i,
   input  logic                 sys_reg_wr_en_i,
   input  logic [`EXC_W-1:0]    sys_exception_i,
   input  logic                 is_mret_i,
   output logic                 valid_o,
   output logic [`EXC_W-1:0]    exception_o,
   output logic                 is_mret_o,
   output logic                 csr_en_o,
   output logic [`CSR_OP_W-1:0] csr_op_o,
   output logic                 csr_source_sel_o,
   output logic [`ALU_OP_W-1:0] alu_op_o,
   output logic                 mdu_en_o,
   output logic [`MDU_OP_W-1:0] mdu_op_o,
   output logic [`CS_W-1:0]     chip_select_o,
   output logic                 rs2_negate_sel_o,
   output logic                 reg_wr_en_o,
   output logic [`WB_W-1:0]     wb_sel_o,
   output logic                 op1_sel_o,
   output logic                 op2_sel_o,
   output logic                 is_load_o,
   output logic                 is_store_o
);

   localparam int CTRL_W = `EXC_W + `CSR_OP_W + `ALU_OP_W + `MDU_OP_W + `CS_W + `WB_W + 10;

   logic                any_legal;
   logic [`CS_W-1:0]    chip_sel_d;
   logic [`EXC_W-1:0]   exc_d;
   logic [CTRL_W-1:0]   ctrl_d;
   logic [CTRL_W-1:0]   ctrl_q;
   logic                valid_q;

   assign any_legal  = int_legal_i | md_legal_i | sys_legal_i;
   assign chip_sel_d = md_legal_i ? `CS_MDU : (csr_en_i ? `CS_CSR : `CS_ALU);
   assign exc_d      = any_legal ? sys_exception_i : `EXC_ILLEGAL;

   // Groups are disjoint and zero their fields when not legal
   assign ctrl_d = {exc_d, is_mret_i, csr_en_i, csr_op_i, csr_source_sel_i,
                    alu_op_i, mdu_en_i, mdu_op_i, chip_sel_d, rs2_negate_sel_i,
                    int_reg_wr_en_i | md_reg_wr_en_i | sys_reg_wr_en_i,
                    wb_sel_i, op1_sel_i, op2_sel_i, is_load_i, is_store_i};

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= instr_valid_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ctrl_q <= '0;
      end else begin
         ctrl_q <= ctrl_d;
      end
   end

   assign valid_o = valid_q;

   assign {exception_o, is_mret_o, csr_en_o, csr_op_o, csr_source_sel_o,
           alu_op_o, mdu_en_o, mdu_op_o, chip_select_o, rs2_negate_sel_o,
           reg_wr_en_o, wb_sel_o, op1_sel_o, op2_sel_o, is_load_o,
           is_store_o} = valid_q ? ctrl_q : '0;

endmodule

/* verilog/system_decoder.sv */
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module system_decoder (
   input  rv_decode_pkg::rv_instr_u instr_i,
   output logic                     sys_legal_o,
   output logic                     csr_en_o,
   output logic [`CSR_OP_W-1:0]     csr_op_o,
   output logic                     csr_source_sel_o,
   output logic                     sys_reg_wr_en_o,
   output logic [`EXC_W-1:0]        sys_exception_o,
   output logic                     is_mret_o
);

   logic [2:0] funct3;
   logic       regs_zero;

   assign funct3    = instr_i.imm.funct3;
   assign regs_zero = (instr_i.imm.rd == 5'd0) && (instr_i.imm.rs1 == 5'd0);

   always_comb begin
      sys_legal_o      = 1'b0;
      csr_en_o         = 1'b0;
      csr_op_o         = '0;
      csr_source_sel_o = 1'b0;
      sys_reg_wr_en_o  = 1'b0;
      sys_exception_o  = `EXC_NONE;
      is_mret_o        = 1'b0;

      if (instr_i.imm.opcode == `OPC_SYSTEM) begin
         if (funct3 != 3'b000) begin
            // CSR access, bit 2 picks the zimm source
            sys_legal_o      = (funct3 != 3'b100);
            csr_en_o         = sys_legal_o;
            csr_op_o         = sys_legal_o ? funct3[1:0] : '0;
            csr_source_sel_o = sys_legal_o & funct3[2];
            sys_reg_wr_en_o  = sys_legal_o;
         end else if (regs_zero) begin
            case (instr_i.imm.funct12)
               `F12_ECALL: begin
                  sys_legal_o     = 1'b1;
                  sys_exception_o = `EXC_ECALL;
               end
               `F12_EBREAK: begin
                  sys_legal_o     = 1'b1;
                  sys_exception_o = `EXC_EBREAK;
               end
               `F12_MRET: begin
                  sys_legal_o = 1'b1;
                  is_mret_o   = 1'b1;
               end
               // WFI behaves as a no-op here
               `F12_WFI: sys_legal_o = 1'b1;
               default: ;
            endcase
         end
      end
   end

endmodule

/* verilog/muldiv_decoder.sv */
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module muldiv_decoder (
   input  rv_decode_pkg::rv_instr_u instr_i,
   input  logic                     is_m_supported_i,
   output logic                     md_legal_o,
   output logic                     mdu_en_o,
   output logic [`MDU_OP_W-1:0]     mdu_op_o,
   output logic                     md_reg_wr_en_o
);

   // All eight funct3 values are valid M operations
   assign md_legal_o = (instr_i.regs.opcode == `OPC_OP) &&
                       (instr_i.regs.funct7 == `F7_MULDIV) &&
                       is_m_supported_i;

   assign mdu_en_o       = md_legal_o;
   assign mdu_op_o       = md_legal_o ? instr_i.regs.funct3 : '0;
   assign md_reg_wr_en_o = md_legal_o;

endmodule

/* verilog/base_int_decoder.sv */
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module base_int_decoder (
   input  rv_decode_pkg::rv_instr_u instr_i,
   output logic                     int_legal_o,
   output logic [`ALU_OP_W-1:0]     alu_op_o,
   output logic                     rs2_negate_sel_o,
   output logic                     reg_wr_en_o,
   output logic [`WB_W-1:0]         wb_sel_o,
   output logic                     op1_sel_o,
   output logic                     op2_sel_o,
   output logic                     is_load_o,
   output logic                     is_store_o
);

   logic [2:0] funct3;
   logic       alt;

   assign funct3 = instr_i.regs.funct3;
   assign alt    = (instr_i.regs.funct7 == `F7_ALT);

   function automatic logic [`ALU_OP_W-1:0] arith_op(input logic [2:0] f3,
                                                     input logic use_alt);
      case (f3)
         3'b000:  arith_op = use_alt ? `ALU_SUB : `ALU_ADD;
         3'b001:  arith_op = `ALU_SLL;
         3'b010:  arith_op = `ALU_SLT;
         3'b011:  arith_op = `ALU_SLTU;
         3'b100:  arith_op = `ALU_XOR;
         3'b101:  arith_op = use_alt ? `ALU_SRA : `ALU_SRL;
         3'b110:  arith_op = `ALU_OR;
         default: arith_op = `ALU_AND;
      endcase
   endfunction

   always_comb begin
      int_legal_o      = 1'b0;
      alu_op_o         = `ALU_ADD;
      rs2_negate_sel_o = 1'b0;
      reg_wr_en_o      = 1'b0;
      wb_sel_o         = `WB_EXEC;
      op1_sel_o        = 1'b0;
      op2_sel_o        = 1'b1;
      is_load_o        = 1'b0;
      is_store_o       = 1'b0;

      case (instr_i.regs.opcode)
         `OPC_LOAD: begin
            int_legal_o = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
            reg_wr_en_o = 1'b1;
            wb_sel_o    = `WB_MEM;
            is_load_o   = 1'b1;
         end
         `OPC_STORE: begin
            int_legal_o = funct3 inside {3'b000, 3'b001, 3'b010};
            is_store_o  = 1'b1;
         end
         `OPC_BRANCH: begin
            // funct3 010 and 011 are unused
            int_legal_o = (funct3[2:1] != 2'b01);
            op1_sel_o   = 1'b1;
         end
         `OPC_JALR: begin
            int_legal_o = (funct3 == 3'b000);
            reg_wr_en_o = 1'b1;
            wb_sel_o    = `WB_LINK;
         end
         `OPC_JAL: begin
            int_legal_o = 1'b1;
            reg_wr_en_o = 1'b1;
            wb_sel_o    = `WB_LINK;
            op1_sel_o   = 1'b1;
         end
         `OPC_AUIPC: begin
            int_legal_o = 1'b1;
            reg_wr_en_o = 1'b1;
            op1_sel_o   = 1'b1;
         end
         `OPC_LUI: begin
            int_legal_o = 1'b1;
            reg_wr_en_o = 1'b1;
            alu_op_o    = `ALU_PASS_B;
         end
         `OPC_OP_IMM: begin
            // Shift amounts sit in the rs2 field, funct7 must be clean
            case (funct3)
               3'b001:  int_legal_o = (instr_i.regs.funct7 == `F7_BASE);
               3'b101:  int_legal_o = (instr_i.regs.funct7 == `F7_BASE) || alt;
               default: int_legal_o = 1'b1;
            endcase
            alu_op_o    = arith_op(funct3, alt && (funct3 == 3'b101));
            reg_wr_en_o = 1'b1;
         end
         `OPC_OP: begin
            int_legal_o      = (instr_i.regs.funct7 == `F7_BASE) ||
                               (alt && (funct3 == 3'b000 || funct3 == 3'b101));
            alu_op_o         = arith_op(funct3, alt);
            rs2_negate_sel_o = alt && (funct3 == 3'b000);
            reg_wr_en_o      = 1'b1;
            op2_sel_o        = 1'b0;
         end
         default: ;
      endcase

      if (!int_legal_o) begin
         alu_op_o         = '0;
         rs2_negate_sel_o = 1'b0;
         reg_wr_en_o      = 1'b0;
         wb_sel_o         = '0;
         op1_sel_o        = 1'b0;
         op2_sel_o        = 1'b0;
         is_load_o        = 1'b0;
         is_store_o       = 1'b0;
      end
   end

endmodule

/* verilog/rv_decode_pkg.sv */
package rv_decode_pkg;

   // One instruction word, bits 31..2, seen as R-type or as I-type
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [4:0] opcode;
      } regs;
      struct packed {
         logic [11:0] funct12;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [4:0]  opcode;
      } imm;
   } rv_instr_u;

endpackage

/* verilog/rv_decode_config.svh */
`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

// Field widths
`define INSTR_W      30
`define ALU_OP_W     4
`define MDU_OP_W     3
`define CSR_OP_W     2
`define EXC_W        2
`define CS_W         2
`define WB_W         2

// Major opcodes, instruction bits 6..2
`define OPC_LOAD     5'b00000
`define OPC_STORE    5'b01000
`define OPC_BRANCH   5'b11000
`define OPC_JALR     5'b11001
`define OPC_JAL      5'b11011
`define OPC_AUIPC    5'b00101
`define OPC_LUI      5'b01101
`define OPC_OP_IMM   5'b00100
`define OPC_OP       5'b01100
`define OPC_SYSTEM   5'b11100

`define F7_BASE      7'b0000000
`define F7_ALT       7'b0100000
`define F7_MULDIV    7'b0000001

// Privileged funct12 values
`define F12_ECALL    12'b0000000_00000
`define F12_EBREAK   12'b0000000_00001
`define F12_MRET     12'b0011000_00010
`define F12_WFI      12'b0001000_00101

`define ALU_ADD      4'b0000
`define ALU_SUB      4'b0001
`define ALU_SLL      4'b0011
`define ALU_SLT      4'b0100
`define ALU_SLTU     4'b0101
`define ALU_XOR      4'b0110
`define ALU_SRL      4'b0111
`define ALU_SRA      4'b1000
`define ALU_OR       4'b1001
`define ALU_AND      4'b1010
`define ALU_PASS_B   4'b1100

`define EXC_NONE     2'b00
`define EXC_ILLEGAL  2'b01
`define EXC_ECALL    2'b10
`define EXC_EBREAK   2'b11

`define CS_ALU       2'b00
`define CS_MDU       2'b01
`define CS_CSR       2'b11

`define WB_EXEC      2'b00
`define WB_MEM       2'b01
`define WB_LINK      2'b11

`endif
